//--- src.f
logic/cache_geom_pkg.sv
logic/cache_ctrl_pkg.sv
logic/meta_if.sv
logic/plru_tree.sv
logic/l2_datapath.sv
logic/l2_control.sv
logic/l2_cache.sv
verification/l2_cache_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= src.f
TB_TOP     ?= l2_cache_tb
RTL_TOP    ?= l2_cache
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall --timing
SIM_FLAGS  ?= --timing -Wno-fatal
PASS_MSG   ?= Simulation PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/l2_cache_tb.sv
module l2_cache_tb
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;
();

    localparam int SET_BITS        = 3;
    localparam int NUM_SETS        = 1 << SET_BITS;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int ACCESS_TIMEOUT  = 60;  // worst case is write-back plus refill

    logic     clk = 1'b0;
    logic     reset;
    logic     mem_read;
    logic     mem_write;
    addr_t    mem_address;
    line_t    mem_wdata;
    byte_en_t mem_byte_enable;
    line_t    mem_rdata;
    logic     resp;
    logic     cacheline_read;
    logic     cacheline_write;
    addr_t    cacheline_address;
    line_t    cacheline_wdata;
    line_t    cacheline_rdata;
    logic     cacheline_resp;
    counter_t hit_count;
    counter_t miss_count;

    integer seed = 32'h5d714b59;

    // memory contents and the flat view that every read must match
    line_t mem_store [addr_t];
    line_t golden [addr_t];
    logic  log_write [$];
    addr_t log_addr [$];
    line_t log_data [$];

    // per-set model of the cache state
    addr_t      model_addr  [NUM_SETS][NUM_WAYS];
    logic       model_valid [NUM_SETS][NUM_WAYS];
    logic       model_dirty [NUM_SETS][NUM_WAYS];
    logic [6:0] model_tree  [NUM_SETS];

    logic  pred_hit;
    logic  pred_wb;
    addr_t pred_victim_addr;
    int    hit_tally;
    int    miss_tally;
    int    error_count;
    int    check_total;
    int    test_count;

    always #20 clk = ~clk;

    l2_cache #(
        .SET_BITS (SET_BITS)
    ) i_l2_cache (
        .clk               (clk),
        .reset             (reset),
        .mem_read          (mem_read),
        .mem_write         (mem_write),
        .mem_address       (mem_address),
        .mem_wdata         (mem_wdata),
        .mem_byte_enable   (mem_byte_enable),
        .mem_rdata         (mem_rdata),
        .resp              (resp),
        .cacheline_read    (cacheline_read),
        .cacheline_write   (cacheline_write),
        .cacheline_address (cacheline_address),
        .cacheline_wdata   (cacheline_wdata),
        .cacheline_rdata   (cacheline_rdata),
        .cacheline_resp    (cacheline_resp),
        .hit_count         (hit_count),
        .miss_count        (miss_count)
    );

    function automatic line_t fill_line(input addr_t line_addr);
        line_t l;
        for (int w = 0; w < LINE_BITS / 32; w++) begin
            l[32*w +: 32] = line_addr + addr_t'(4 * w);  // each word holds its own address
        end
        return l;
    endfunction

    function automatic line_t stored_line(input addr_t a);
        return mem_store.exists(a) ? mem_store[a] : fill_line(a);
    endfunction

    function automatic line_t golden_line(input addr_t a);
        return golden.exists(a) ? golden[a] : fill_line(a);
    endfunction

    function automatic line_t merge_bytes(input line_t old, input line_t wdata, input byte_en_t be);
        line_t l;
        l = old;
        for (int b = 0; b < LINE_BITS / 8; b++) begin
            if (be[b]) l[8*b +: 8] = wdata[8*b +: 8];
        end
        return l;
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int w = 0; w < LINE_BITS / 32; w++) begin
            l[32*w +: 32] = $random(seed);
        end
        return l;
    endfunction

    function automatic addr_t make_addr(input int tag, input int set_num);
        return (addr_t'(tag) << (SET_BITS + OFFSET_BITS)) | (addr_t'(set_num) << OFFSET_BITS);
    endfunction

    // heap layout with the children of node n at 2n+1 and 2n+2
    function automatic way_idx_t tree_victim(input logic [6:0] bits);
        int       node;
        way_idx_t v;
        node = 0;
        v = '0;
        for (int lvl = 0; lvl < 3; lvl++) begin
            v = {v[1:0], bits[node]};
            node = 2 * node + 1 + int'(bits[node]);
        end
        return v;
    endfunction

    function automatic logic [6:0] tree_touch(input logic [6:0] bits, input way_idx_t way);
        int node;
        node = 0;
        for (int lvl = 2; lvl >= 0; lvl--) begin
            bits[node] = ~way[lvl];  // point away from the touched way
            node = 2 * node + 1 + int'(way[lvl]);
        end
        return bits;
    endfunction

    task automatic check_line(input string name, input line_t got, input line_t exp);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input counter_t got, input counter_t exp);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic note_failure(input string what);
        error_count++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name, error_count - errs_before);
        end
    endtask

    // line memory answering after 1 to 6 cycles
    initial begin : memory_model
        int unsigned wait_left;
        logic        busy;
        cacheline_resp = 1'b0;
        cacheline_rdata = '0;
        busy = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            if (reset || cacheline_resp) begin
                cacheline_resp <= 1'b0;
            end else if (cacheline_read || cacheline_write) begin
                if (!busy) begin
                    busy = 1'b1;
                    wait_left = 1 + ($unsigned($random(seed)) % 6);
                end
                if (wait_left > 1) begin
                    wait_left--;
                end else begin
                    busy = 1'b0;
                    log_write.push_back(cacheline_write);
                    log_addr.push_back(cacheline_address);
                    log_data.push_back(cacheline_wdata);
                    if (cacheline_write) mem_store[cacheline_address] = cacheline_wdata;
                    else cacheline_rdata <= stored_line(cacheline_address);
                    cacheline_resp <= 1'b1;
                end
            end
        end
    end

    // one request predicted from the model and checked against memory traffic
    task automatic do_access(input logic is_write, input addr_t addr, input line_t wdata,
                             input byte_en_t be);
        addr_t line_addr;
        int    set_num;
        int    way;
        int    cycles;
        int    exp_txn;
        logic  got_resp;
        line_t got;
        line_t exp_rdata;

        line_addr = addr & ~addr_t'(LINE_BITS / 8 - 1);
        set_num = int'(addr[OFFSET_BITS +: SET_BITS]);
        pred_hit = 1'b0;
        pred_wb = 1'b0;
        way = 0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (model_valid[set_num][w] && model_addr[set_num][w] == line_addr) begin
                pred_hit = 1'b1;
                way = w;
            end
        end
        if (!pred_hit) begin
            way = int'(tree_victim(model_tree[set_num]));
            pred_victim_addr = model_addr[set_num][way];
            pred_wb = model_valid[set_num][way] && model_dirty[set_num][way];
        end
        exp_rdata = golden_line(line_addr);
        log_write.delete();
        log_addr.delete();
        log_data.delete();

        @(posedge clk);
        mem_read        <= !is_write;
        mem_write       <= is_write;
        mem_address     <= addr;
        mem_wdata       <= wdata;
        mem_byte_enable <= be;
        cycles = 0;
        got_resp = 1'b0;
        while (!got_resp && cycles < ACCESS_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            got_resp = resp;
            got = mem_rdata;
        end
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
        if (!got_resp) begin
            note_failure($sformatf("no resp within %0d cycles for address %h",
                                   ACCESS_TIMEOUT, addr));
            return;
        end

        if (pred_hit) begin
            hit_tally++;
            if (cycles != 1) note_failure("hit did not respond in the request cycle");
            check_count("memory transactions", counter_t'(log_addr.size()), 32'd0);
        end else begin
            miss_tally++;
            exp_txn = pred_wb ? 2 : 1;
            check_count("memory transactions", counter_t'(log_addr.size()), counter_t'(exp_txn));
            if (log_addr.size() == exp_txn) begin
                if (pred_wb) begin
                    if (!log_write[0]) note_failure("victim write-back missing before refill");
                    check_addr("cacheline_address", log_addr[0], pred_victim_addr);
                    check_line("cacheline_wdata", log_data[0], golden_line(pred_victim_addr));
                end
                if (log_write[exp_txn-1]) note_failure("refill read missing");
                check_addr("cacheline_address", log_addr[exp_txn-1], line_addr);
            end
        end
        if (!is_write) check_line("mem_rdata", got, exp_rdata);

        model_addr[set_num][way] = line_addr;
        model_valid[set_num][way] = 1'b1;
        model_dirty[set_num][way] = pred_hit ? (model_dirty[set_num][way] | is_write) : is_write;
        model_tree[set_num] = tree_touch(model_tree[set_num], way_idx_t'(way));
        if (is_write) golden[line_addr] = merge_bytes(exp_rdata, wdata, be);
    endtask

    // keep missing in the set until the target line is the victim
    task automatic evict_line(input addr_t target, input int set_num, input int tag_base);
        int   i;
        logic found;
        found = 1'b0;
        i = 0;
        while (!found && i < 16) begin
            do_access(1'b0, make_addr(tag_base + i, set_num), '0, '0);
            found = !pred_hit && pred_victim_addr == target;
            i++;
        end
    endtask

    task automatic test_read_miss_hit();
        int    errs;
        addr_t a;
        errs = error_count;
        a = make_addr(32'h012, 2) | 32'h14;
        do_access(1'b0, a, '0, '0);
        do_access(1'b0, a, '0, '0);
        finish_test("read miss then read hit", errs);
    endtask

    task automatic test_write_hit_partial();
        int    errs;
        addr_t a;
        errs = error_count;
        a = make_addr(32'h012, 2);
        do_access(1'b1, a, random_line(), 32'h0ff0_00c3);
        do_access(1'b0, a, '0, '0);  // only enabled bytes differ from the fill
        finish_test("partial write hit and read back", errs);
    endtask

    task automatic test_set_eviction();
        int    errs;
        addr_t evicted;
        errs = error_count;
        for (int i = 0; i < 9; i++) begin
            do_access(1'b0, make_addr(32'h100 + i, 5), '0, '0);
        end
        evicted = pred_victim_addr;
        // the eight survivors must all hit
        for (int i = 0; i < 9; i++) begin
            if (make_addr(32'h100 + i, 5) != evicted) begin
                do_access(1'b0, make_addr(32'h100 + i, 5), '0, '0);
            end
        end
        do_access(1'b0, evicted, '0, '0);
        finish_test("nine tags in one set", errs);
    endtask

    task automatic test_dirty_eviction();
        int    errs;
        addr_t a;
        errs = error_count;
        a = make_addr(32'h200, 6);
        do_access(1'b0, a, '0, '0);
        do_access(1'b1, a, random_line(), 32'h00ff_00f0);
        evict_line(a, 6, 32'h201);
        do_access(1'b0, a, '0, '0);  // merged data comes back from memory
        finish_test("write-back of a dirty line", errs);
    endtask

    task automatic test_write_allocate();
        int    errs;
        addr_t a;
        errs = error_count;
        a = make_addr(32'h300, 1) | 32'h08;
        do_access(1'b1, a, random_line(), 32'hf0f0_0f0f);
        do_access(1'b0, a, '0, '0);
        evict_line(a & ~addr_t'(LINE_BITS / 8 - 1), 1, 32'h301);
        finish_test("write miss with allocate", errs);
    endtask

    task automatic test_flush_ignored();
        int errs;
        int resp_seen;
        int traffic_seen;
        errs = error_count;
        resp_seen = 0;
        traffic_seen = 0;
        @(posedge clk);
        mem_read        <= 1'b1;
        mem_write       <= 1'b1;
        mem_address     <= make_addr(32'h012, 2);
        mem_wdata       <= random_line();
        mem_byte_enable <= '1;
        repeat (20) begin
            @(posedge clk);
            if (resp) resp_seen++;
            if (cacheline_read || cacheline_write) traffic_seen++;
        end
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
        @(posedge clk);
        if (resp_seen != 0) note_failure("read and write together produced a resp");
        if (traffic_seen != 0) note_failure("read and write together reached the memory");
        check_count("hit_count", hit_count, counter_t'(hit_tally));
        check_count("miss_count", miss_count, counter_t'(miss_tally));
        finish_test("flush request ignored, counters", errs);
    endtask

    initial begin : watchdog
        repeat (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles",
                 RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_address = '0;
        mem_wdata = '0;
        mem_byte_enable = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            model_tree[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                model_addr[s][w] = '0;
                model_valid[s][w] = 1'b0;
                model_dirty[s][w] = 1'b0;
            end
        end
        hit_tally = 0;
        miss_tally = 0;
        error_count = 0;
        check_total = 0;
        test_count = 0;
        pred_victim_addr = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        if (resp || cacheline_read || cacheline_write) note_failure("handshakes high after reset");
        check_count("hit_count", hit_count, 32'd0);
        check_count("miss_count", miss_count, 32'd0);

        test_read_miss_hit();
        test_write_hit_partial();
        test_set_eviction();
        test_dirty_eviction();
        test_write_allocate();
        test_flush_ignored();

        @(posedge clk);
        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_total, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- logic/l2_cache.sv
module l2_cache
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;
#(
    parameter int SET_BITS = 3  // eight sets
) (
    input  logic     clk,
    input  logic     reset,

    // upper level
    input  logic     mem_read,
    input  logic     mem_write,
    input  addr_t    mem_address,
    input  line_t    mem_wdata,
    input  byte_en_t mem_byte_enable,
    output line_t    mem_rdata,
    output logic     resp,

    // line memory
    output logic     cacheline_read,
    output logic     cacheline_write,
    output addr_t    cacheline_address,
    output line_t    cacheline_wdata,
    input  line_t    cacheline_rdata,
    input  logic     cacheline_resp,

    output counter_t hit_count,
    output counter_t miss_count
);

    meta_if meta ();

    l2_datapath #(
        .SET_BITS (SET_BITS)
    ) i_l2_datapath (
        .clk               (clk),
        .reset             (reset),
        .meta              (meta.dp),
        .mem_address       (mem_address),
        .mem_wdata         (mem_wdata),
        .mem_byte_enable   (mem_byte_enable),
        .mem_write         (mem_write),
        .mem_rdata         (mem_rdata),
        .cacheline_rdata   (cacheline_rdata),
        .cacheline_write   (cacheline_write),
        .cacheline_wdata   (cacheline_wdata),
        .cacheline_address (cacheline_address)
    );

    l2_control i_l2_control (
        .clk             (clk),
        .reset           (reset),
        .meta            (meta.ctrl),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .resp            (resp),
        .cacheline_resp  (cacheline_resp),
        .cacheline_read  (cacheline_read),
        .cacheline_write (cacheline_write),
        .hit_count       (hit_count),
        .miss_count      (miss_count)
    );

endmodule

//--- logic/l2_control.sv
module l2_control
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    meta_if.ctrl     meta,

    // requester side
    input  logic     mem_read,
    input  logic     mem_write,
    output logic     resp,

    // memory side
    input  logic     cacheline_resp,
    output logic     cacheline_read,
    output logic     cacheline_write,

    output counter_t hit_count,
    output counter_t miss_count
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    way_mask_t hit_ways;
    way_mask_t victim_mask;
    way_idx_t  victim_way;   // way being refilled
    logic      req;
    logic      hit;
    logic      victim_dirty;
    logic      claim;        // take over the victim way for the new tag

    // read and write together is a flush, which is ignored
    assign req = mem_read ^ mem_write;

    assign hit_ways     = meta.cmp & meta.valid;
    assign hit          = |hit_ways;
    assign victim_mask  = way_decode(meta.lru);
    assign victim_dirty = |(victim_mask & meta.dirty & meta.valid);

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (req && !hit) next_state = victim_dirty ? st_write_back : st_read_mem;
            end
            st_write_back: begin
                if (cacheline_resp) next_state = st_meta_update;
            end
            st_meta_update: next_state = st_read_mem;
            st_read_mem: begin
                if (cacheline_resp) next_state = mem_write ? st_write_end : st_read_end;
            end
            st_read_end, st_write_end: next_state = st_wait0;
            default: next_state = st_idle;  // wait0 lets the requester drop the request
        endcase
    end

    always_comb begin
        meta.sel         = way_encode(hit_ways);
        meta.mru         = way_encode(hit_ways);
        meta.data_in_sel = 1'b0;
        meta.write_en    = '0;
        meta.load_tag    = '0;
        meta.load_lru    = 1'b0;
        meta.load_valid  = 1'b0;
        meta.valid_in    = meta.valid;
        meta.load_dirty  = 1'b0;
        meta.dirty_in    = meta.dirty;
        resp             = 1'b0;
        cacheline_read   = 1'b0;
        cacheline_write  = 1'b0;
        claim            = 1'b0;

        case (state)
            st_idle: begin
                if (req && hit) begin
                    resp          = 1'b1;
                    meta.load_lru = 1'b1;
                    if (mem_write) begin  // write hit merges in place
                        meta.write_en   = hit_ways;
                        meta.dirty_in   = meta.dirty | hit_ways;
                        meta.load_dirty = 1'b1;
                    end
                end else if (req && !victim_dirty) begin
                    claim = 1'b1;  // clean miss
                end
            end
            st_write_back: begin
                meta.sel        = meta.lru;
                cacheline_write = 1'b1;
            end
            st_meta_update: claim = 1'b1;
            st_read_mem: begin
                meta.data_in_sel = 1'b1;
                cacheline_read   = 1'b1;
                if (cacheline_resp) meta.write_en = way_decode(victim_way);
            end
            st_read_end: resp = 1'b1;
            st_write_end: begin
                resp          = 1'b1;
                meta.write_en = hit_ways;
            end
            default: ;
        endcase

        // new tag is valid, dirty only for a write
        if (claim) begin
            meta.mru        = meta.lru;
            meta.load_lru   = 1'b1;
            meta.load_tag   = victim_mask;
            meta.valid_in   = meta.valid | victim_mask;
            meta.load_valid = 1'b1;
            meta.dirty_in   = mem_write ? (meta.dirty | victim_mask)
                                        : (meta.dirty & ~victim_mask);
            meta.load_dirty = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (claim) victim_way <= meta.lru;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            state <= next_state;
            if (state == st_idle && req) begin  // once per request
                if (hit) hit_count <= hit_count + 32'd1;
                else miss_count <= miss_count + 32'd1;
            end
        end
    end

endmodule

//--- logic/l2_datapath.sv
module l2_datapath
    import cache_geom_pkg::*;
#(
    parameter int SET_BITS = 3
) (
    input  logic     clk,
    input  logic     reset,

    meta_if.dp       meta,

    // requester side
    input  addr_t    mem_address,
    input  line_t    mem_wdata,
    input  byte_en_t mem_byte_enable,
    input  logic     mem_write,
    output line_t    mem_rdata,

    // memory side
    input  line_t    cacheline_rdata,
    input  logic     cacheline_write,
    output line_t    cacheline_wdata,
    output addr_t    cacheline_address
);

    localparam int NUM_SETS = 1 << SET_BITS;
    localparam int TAG_BITS = 32 - SET_BITS - OFFSET_BITS;

    logic [TAG_BITS-1:0] tag_array [NUM_SETS][NUM_WAYS];
    line_t               data_array [NUM_SETS][NUM_WAYS];
    way_mask_t           valid_bits [NUM_SETS];
    way_mask_t           dirty_bits [NUM_SETS];

    logic [SET_BITS-1:0] set_idx;
    logic [TAG_BITS-1:0] req_tag;
    logic [TAG_BITS-1:0] sel_tag;
    line_t               cur_line;
    line_t               merged_line;
    line_t               data_in;
    byte_en_t            wr_mask;

    assign set_idx = mem_address[OFFSET_BITS +: SET_BITS];
    assign req_tag = mem_address[OFFSET_BITS + SET_BITS +: TAG_BITS];

    // combinational array reads for the addressed set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            meta.cmp[w] = (tag_array[set_idx][w] == req_tag);
        end
    end

    assign meta.valid = valid_bits[set_idx];
    assign meta.dirty = dirty_bits[set_idx];

    assign cur_line = data_array[set_idx][meta.sel];
    assign sel_tag  = tag_array[set_idx][meta.sel];

    // a read request never merges requester bytes
    assign wr_mask = mem_write ? mem_byte_enable : '0;

    always_comb begin
        for (int b = 0; b < LINE_BITS / 8; b++) begin
            merged_line[8*b +: 8] = wr_mask[b] ? mem_wdata[8*b +: 8] : cur_line[8*b +: 8];
        end
    end

    assign data_in = meta.data_in_sel ? cacheline_rdata : merged_line;

    // tags and data
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (meta.write_en[w]) data_array[set_idx][w] <= data_in;
            if (meta.load_tag[w]) tag_array[set_idx][w] <= req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_bits[s] <= '0;
                dirty_bits[s] <= '0;
            end
        end else begin
            if (meta.load_valid) valid_bits[set_idx] <= meta.valid_in;
            if (meta.load_dirty) dirty_bits[set_idx] <= meta.dirty_in;
        end
    end

    plru_tree #(
        .SET_BITS (SET_BITS)
    ) i_plru_tree (
        .clk       (clk),
        .reset     (reset),
        .set_index (set_idx),
        .load_lru  (meta.load_lru),
        .mru       (meta.mru),
        .lru       (meta.lru)
    );

    // write-back goes to the victim's own tag, everything else to the request
    assign cacheline_address = cacheline_write ? {sel_tag, set_idx, {OFFSET_BITS{1'b0}}}
                                               : {req_tag, set_idx, {OFFSET_BITS{1'b0}}};

    assign mem_rdata       = cur_line;
    assign cacheline_wdata = cur_line;

endmodule

//--- logic/plru_tree.sv
module plru_tree
    import cache_geom_pkg::*;
#(
    parameter int SET_BITS = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [SET_BITS-1:0] set_index,
    input  logic                load_lru,
    input  way_idx_t            mru,
    output way_idx_t            lru
);

    localparam int NUM_SETS = 1 << SET_BITS;

    // bit 0 root, 1-2 second level, 3-6 leaves
    logic [6:0] tree [NUM_SETS];
    logic [6:0] cur_bits;
    logic [6:0] next_bits;
    logic       half;
    logic       quarter;
    logic       leaf;

    // a 0 bit sends the walk to the lower-numbered half
    always_comb begin
        cur_bits = tree[set_index];
        half     = cur_bits[0];
        quarter  = cur_bits[1 + half];
        leaf     = cur_bits[3 + {half, quarter}];
        lru      = {half, quarter, leaf};
    end

    // point every node on the touched path away from it
    always_comb begin
        next_bits = cur_bits;
        next_bits[0] = ~mru[2];
        next_bits[1 + mru[2]] = ~mru[1];
        next_bits[3 + mru[2:1]] = ~mru[0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < NUM_SETS; s++) tree[s] <= '0;  // first victim is way 0
        end else if (load_lru) begin
            tree[set_index] <= next_bits;
        end
    end

endmodule

//--- logic/meta_if.sv
interface meta_if
    import cache_geom_pkg::*;
();

    // datapath to controller
    way_mask_t cmp;          // raw tag match per way
    way_mask_t valid;
    way_mask_t dirty;
    way_idx_t  lru;          // victim of addressed set

    // controller to datapath
    way_idx_t  sel;          // way driven onto the read data
    logic      data_in_sel;  // 1 = memory line, 0 = merged requester line
    way_mask_t write_en;
    way_mask_t load_tag;
    logic      load_valid;
    way_mask_t valid_in;
    logic      load_dirty;
    way_mask_t dirty_in;
    logic      load_lru;
    way_idx_t  mru;

    modport dp (
        output cmp, valid, dirty, lru,
        input  sel, data_in_sel, write_en, load_tag, load_valid, valid_in,
        input  load_dirty, dirty_in, load_lru, mru
    );

    modport ctrl (
        input  cmp, valid, dirty, lru,
        output sel, data_in_sel, write_en, load_tag, load_valid, valid_in,
        output load_dirty, dirty_in, load_lru, mru
    );

endinterface

//--- logic/cache_ctrl_pkg.sv
package cache_ctrl_pkg;
    import cache_geom_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_write_back,   // victim line going out
        st_meta_update,
        st_read_mem,     // refill in flight
        st_read_end,
        st_write_end,    // merge requester bytes into refilled line
        st_wait0
    } ctrl_state_t;

    typedef logic [31:0] counter_t;

    // lowest set bit wins if the mask is not one-hot
    function automatic way_idx_t way_encode(way_mask_t mask);
        way_idx_t idx;
        idx = '0;
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (mask[i]) idx = way_idx_t'(i);
        end
        return idx;
    endfunction

    function automatic way_mask_t way_decode(way_idx_t idx);
        return way_mask_t'(1) << idx;
    endfunction

endpackage

//--- logic/cache_geom_pkg.sv
package cache_geom_pkg;

    localparam int NUM_WAYS    = 8;  // tree and encoders assume eight
    localparam int LINE_BITS   = 256;
    localparam int OFFSET_BITS = 5;  // byte offset within a line

    typedef logic [31:0] addr_t;

    // way numbering and way vectors
    typedef logic [$clog2(NUM_WAYS)-1:0] way_idx_t;
    typedef logic [NUM_WAYS-1:0]         way_mask_t;

    typedef logic [LINE_BITS-1:0]   line_t;
    typedef logic [LINE_BITS/8-1:0] byte_en_t;  // one bit per byte lane

endpackage
